/* logic/eeprom_pkg.sv */
package eeprom_pkg;

    // 24C16 style part, 8 pages of 256 bytes
    localparam int ADDR_W = 11;
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    typedef enum logic
    {
        REQ_WRITE,
        REQ_READ
    } req_kind_t;

    // host request as held for the whole frame
    typedef struct packed
    {
        req_kind_t         kind;
        logic [ADDR_W-1:0] addr;
        logic [7:0]        wdata;
    } mem_req_t;

    typedef enum logic [1:0]
    {
        BIT_START,
        BIT_STOP,
        BIT_SEND,
        BIT_RECV
    } bit_op_t;

    typedef struct packed
    {
        bit_op_t    op;
        logic [7:0] tx_byte;  // only used by BIT_SEND
    } bit_cmd_t;

    // frame sequencer steps
    typedef enum logic [3:0]
    {
        IDLE,
        START,
        CTRL_W,
        ADDR,
        WDATA,
        RESTART,
        CTRL_R,
        RDATA,
        STOP,
        DONE
    } frame_state_t;

endpackage

/* logic/eeprom_req_capture.sv */
`timescale 1ns/1ns

module eeprom_req_capture
(
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                    wdata,
    input  logic                          frame_done,
    input  logic [7:0]                    rx_byte,
    output logic                          req_start,
    output eeprom_pkg::mem_req_t          req,
    output logic                          busy,
    output logic                          ack,
    output logic [7:0]                    rdata
);
    import eeprom_pkg::*;

    logic accept;

    // strobes are dropped while a frame is running
    assign accept = !busy && (wr || rd);

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            busy      <= 1'b0;
            req_start <= 1'b0;
            ack       <= 1'b0;
        end
        else
        begin
            req_start <= accept;
            ack       <= frame_done;
            if (accept)
                busy <= 1'b1;
            else if (frame_done)
                busy <= 1'b0;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            req.kind  <= wr ? REQ_WRITE : REQ_READ;  // wr wins a tie
            req.addr  <= addr;
            req.wdata <= wdata;
        end
    end

    // read byte comes back with frame_done, writes leave rdata alone
    always_ff @(posedge CLK)
    begin
        if (frame_done && req.kind == REQ_READ)
            rdata <= rx_byte;
    end

    // one ack per frame, a single cycle wide
    a_ack_single: assert property (@(posedge CLK) disable iff (RESET)
        ack |=> !ack)
        else $error("ack held for two cycles");

endmodule

/* logic/eeprom_frame_seq.sv */
`timescale 1ns/1ns

module eeprom_frame_seq
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 req_start,
    input  eeprom_pkg::mem_req_t req,
    input  logic                 step_done,
    input  logic [7:0]           step_rx,
    output logic                 cmd_go,
    output eeprom_pkg::bit_cmd_t cmd,
    output logic                 frame_done,
    output logic [7:0]           rx_byte
);
    import eeprom_pkg::*;

    frame_state_t state;
    frame_state_t state_nxt;
    logic         pending;  // a bit engine step is in flight
    logic [7:0]   ctrl_w;
    logic [7:0]   ctrl_r;

    // control byte: device code, page bits, r/w
    assign ctrl_w = {DEVICE_CODE, req.addr[10:8], 1'b0};
    assign ctrl_r = {DEVICE_CODE, req.addr[10:8], 1'b1};

    // step issued in each state
    always_comb
    begin
        cmd.op      = BIT_STOP;
        cmd.tx_byte = 8'h00;
        case (state)
            START, RESTART:
                cmd.op = BIT_START;
            CTRL_W:
            begin
                cmd.op      = BIT_SEND;
                cmd.tx_byte = ctrl_w;
            end
            ADDR:
            begin
                cmd.op      = BIT_SEND;
                cmd.tx_byte = req.addr[7:0];
            end
            WDATA:
            begin
                cmd.op      = BIT_SEND;
                cmd.tx_byte = req.wdata;
            end
            CTRL_R:
            begin
                cmd.op      = BIT_SEND;
                cmd.tx_byte = ctrl_r;
            end
            RDATA:
                cmd.op = BIT_RECV;
            default:
                cmd.op = BIT_STOP;
        endcase
    end

    always_comb
    begin
        case (state)
            START:   state_nxt = CTRL_W;
            CTRL_W:  state_nxt = ADDR;
            ADDR:    state_nxt = (req.kind == REQ_WRITE) ? WDATA : RESTART;
            WDATA:   state_nxt = STOP;
            RESTART: state_nxt = CTRL_R;
            CTRL_R:  state_nxt = RDATA;
            RDATA:   state_nxt = STOP;
            STOP:    state_nxt = DONE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
            pending <= 1'b0;
        else if (cmd_go)
            pending <= 1'b1;
        else if (step_done)
            pending <= 1'b0;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state      <= IDLE;
            cmd_go     <= 1'b0;
            frame_done <= 1'b0;
        end
        else
        begin
            cmd_go     <= 1'b0;
            frame_done <= 1'b0;
            case (state)
                IDLE:
                    if (req_start)
                    begin
                        state  <= START;
                        cmd_go <= 1'b1;
                    end
                DONE:
                begin
                    frame_done <= 1'b1;
                    state      <= IDLE;
                end
                default:
                    if (step_done)
                    begin
                        state  <= state_nxt;
                        cmd_go <= (state_nxt != DONE);  // nothing follows the stop
                    end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == RDATA && step_done)
            rx_byte <= step_rx;  // held until frame_done
    end

    // engine has no queue, one step at a time
    a_one_step: assert property (@(posedge CLK) disable iff (RESET)
        cmd_go |-> !pending)
        else $error("cmd_go while a step is outstanding");

endmodule

/* logic/eeprom_bit_engine.sv */
`timescale 1ns/1ns

module eeprom_bit_engine
#(
    parameter int SCL_HALF = 2  // needs at least 2 so SDA moves inside the low phase
)
(
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 cmd_go,
    input  eeprom_pkg::bit_cmd_t cmd,
    input  logic                 sda_i,
    output logic                 step_done,
    output logic [7:0]           step_rx,
    output logic                 scl,
    output logic                 sda_o,
    output logic                 sda_oe
);
    import eeprom_pkg::*;

    localparam int DIV_W = (SCL_HALF > 1) ? $clog2(SCL_HALF) : 1;
    localparam logic [DIV_W-1:0] HALF_MID = DIV_W'((SCL_HALF - 1) / 2);
    localparam logic [DIV_W-1:0] HALF_END = DIV_W'(SCL_HALF - 1);

    // each step is a run of low/high SCL half periods
    typedef enum logic [1:0]
    {
        PH_IDLE,
        PH_LOW,
        PH_HIGH
    } phase_t;

    phase_t           phase;
    bit_op_t          op;
    logic [7:0]       shreg;
    logic [2:0]       bit_cnt;
    logic [DIV_W-1:0] div;
    logic             last_half;
    logic             edge_step;

    assign last_half = (div == HALF_END);
    assign edge_step = (phase != PH_IDLE) && (op == BIT_START || op == BIT_STOP);
    assign step_rx   = shreg;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            phase     <= PH_IDLE;
            op        <= BIT_STOP;
            div       <= '0;
            bit_cnt   <= '0;
            scl       <= 1'b1;
            sda_o     <= 1'b1;
            sda_oe    <= 1'b0;
            step_done <= 1'b0;
        end
        else
        begin
            step_done <= 1'b0;
            case (phase)
                PH_IDLE:
                begin
                    if (cmd_go)
                    begin
                        op      <= cmd.op;
                        div     <= '0;
                        bit_cnt <= '0;
                        scl     <= 1'b0;  // every step opens with SCL low
                        phase   <= PH_LOW;
                    end
                end
                PH_LOW:
                begin
                    div <= div + DIV_W'(1);
                    if (div == HALF_MID)
                    begin
                        sda_oe <= (op != BIT_RECV);  // slave owns SDA on reads
                        case (op)
                            BIT_START: sda_o <= 1'b1;
                            BIT_STOP:  sda_o <= 1'b0;
                            BIT_SEND:  sda_o <= shreg[7];
                            default:   sda_o <= sda_o;
                        endcase
                    end
                    if (last_half)
                    begin
                        div   <= '0;
                        scl   <= 1'b1;
                        phase <= PH_HIGH;
                    end
                end
                PH_HIGH:
                begin
                    div <= div + DIV_W'(1);
                    if (div == HALF_MID && edge_step)
                        sda_o <= (op == BIT_STOP);  // start falls, stop rises
                    if (last_half)
                    begin
                        div <= '0;
                        if (edge_step || bit_cnt == 3'd7)
                        begin
                            phase     <= PH_IDLE;  // SCL parks high
                            step_done <= 1'b1;
                            if (op == BIT_STOP)
                                sda_oe <= 1'b0;
                        end
                        else
                        begin
                            bit_cnt <= bit_cnt + 3'd1;
                            scl     <= 1'b0;
                            phase   <= PH_LOW;
                        end
                    end
                end
                default:
                    phase <= PH_IDLE;
            endcase
        end
    end

    // msb first, loaded on the step and shifted as SCL rises
    always_ff @(posedge CLK)
    begin
        if (phase == PH_IDLE && cmd_go)
            shreg <= cmd.tx_byte;
        else if (phase == PH_LOW && last_half)
            shreg <= {shreg[6:0], sda_i};
    end

    // data bits only move while SCL is low
    a_sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && sda_oe && $past(sda_oe) && !$past(edge_step))
        |-> $stable(sda_o))
        else $error("SDA changed while SCL high outside start/stop");

endmodule

/* logic/eeprom_ctrl_top.sv */
`timescale 1ns/1ns

module eeprom_ctrl_top
#(
    parameter int SCL_HALF = 2
)
(
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::ADDR_W-1:0] addr,
    input  logic [7:0]                    wdata,
    input  logic                          sda_i,
    output logic                          ack,
    output logic                          busy,
    output logic [7:0]                    rdata,
    output logic                          scl,
    output logic                          sda_o,
    output logic                          sda_oe
);
    import eeprom_pkg::*;

    logic       req_start;
    mem_req_t   req;
    logic       frame_done;
    logic [7:0] rx_byte;
    logic       cmd_go;
    bit_cmd_t   cmd;
    logic       step_done;
    logic [7:0] step_rx;

    eeprom_req_capture i_capture
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .wr         (wr),
        .rd         (rd),
        .addr       (addr),
        .wdata      (wdata),
        .frame_done (frame_done),
        .rx_byte    (rx_byte),
        .req_start  (req_start),
        .req        (req),
        .busy       (busy),
        .ack        (ack),
        .rdata      (rdata)
    );

    eeprom_frame_seq i_seq
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .req_start  (req_start),
        .req        (req),
        .step_done  (step_done),
        .step_rx    (step_rx),
        .cmd_go     (cmd_go),
        .cmd        (cmd),
        .frame_done (frame_done),
        .rx_byte    (rx_byte)
    );

    eeprom_bit_engine #(.SCL_HALF(SCL_HALF)) i_engine
    (
        .CLK        (CLK),
        .RESET      (RESET),
        .cmd_go     (cmd_go),
        .cmd        (cmd),
        .sda_i      (sda_i),
        .step_done  (step_done),
        .step_rx    (step_rx),
        .scl        (scl),
        .sda_o      (sda_o),
        .sda_oe     (sda_oe)
    );

endmodule

/* bench/eeprom_bus_model.sv */
`timescale 1ns/1ns

module eeprom_bus_model
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       scl,
    input  logic       sda_o,
    input  logic       sda_oe,
    output logic       sda_i,
    output logic [7:0] last_ctrl
);
    import eeprom_pkg::*;

    typedef enum logic [2:0]
    {
        M_IDLE,
        M_CTRL,
        M_ADDR,
        M_WDATA,
        M_RDATA
    } model_state_t;

    logic [7:0]   mem [0:(1<<ADDR_W)-1];
    model_state_t state;
    logic         slave_sda;  // 1 when released
    logic         sda;
    logic         scl_q;
    logic         sda_q;
    logic [7:0]   shreg;
    logic [7:0]   in_byte;
    logic [2:0]   bit_cnt;
    logic [2:0]   page;
    logic [7:0]   word_addr;
    logic [7:0]   tx_byte;

    // master owns the line while sda_oe is set
    assign sda     = sda_oe ? sda_o : slave_sda;
    assign sda_i   = sda;
    assign in_byte = {shreg[6:0], sda};

    // every address bit shows up in the pattern
    function automatic logic [7:0] fill_byte(input logic [ADDR_W-1:0] a);
        return a[7:0] ^ {a[10:8], a[10:6]};
    endfunction

    always @(posedge CLK)
    begin
        logic [ADDR_W:0] i;
        if (RESET)
        begin
            for (i = '0; !i[ADDR_W]; i++)
                mem[i[ADDR_W-1:0]] <= fill_byte(i[ADDR_W-1:0]);
            state     <= M_IDLE;
            slave_sda <= 1'b1;
            scl_q     <= 1'b1;
            sda_q     <= 1'b1;
            bit_cnt   <= '0;
            last_ctrl <= '0;
        end
        else
        begin
            scl_q <= scl;
            sda_q <= sda;
            if (scl && scl_q && sda_q && !sda)
            begin
                state   <= M_CTRL;  // start or repeated start
                bit_cnt <= '0;
            end
            else if (scl && scl_q && !sda_q && sda)
                state <= M_IDLE;  // stop
            else if (scl && !scl_q && state != M_IDLE)
            begin
                shreg   <= in_byte;
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7)
                begin
                    case (state)
                        M_CTRL:
                        begin
                            last_ctrl <= in_byte;
                            page      <= in_byte[3:1];
                            if (in_byte[7:4] != DEVICE_CODE)
                                state <= M_IDLE;  // not addressed to us
                            else if (in_byte[0])
                            begin
                                state   <= M_RDATA;
                                tx_byte <= mem[{in_byte[3:1], word_addr}];
                            end
                            else
                                state <= M_ADDR;
                        end
                        M_ADDR:
                        begin
                            word_addr <= in_byte;
                            state     <= M_WDATA;
                        end
                        M_WDATA:
                        begin
                            mem[{page, word_addr}] <= in_byte;
                            state                  <= M_IDLE;
                        end
                        default:
                            state <= M_IDLE;  // read byte fully shifted out
                    endcase
                end
            end
            else if (!scl && scl_q)
                slave_sda <= (state == M_RDATA) ? tx_byte[3'd7 - bit_cnt] : 1'b1;
        end
    end

endmodule

/* bench/eeprom_ctrl_tb.sv */
`timescale 1ns/1ns

module eeprom_ctrl_tb;
    import eeprom_pkg::*;

    localparam int         TIMEOUT  = 2000;
    localparam int         QUIET    = 400;  // longer than a whole write frame
    localparam logic [3:0] DEV_CODE = 4'b1010;

    logic              CLK;
    logic              RESET;
    logic              wr;
    logic              rd;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        wdata;
    logic              sda_i;
    logic              ack;
    logic              busy;
    logic [7:0]        rdata;
    logic              scl;
    logic              sda_o;
    logic              sda_oe;
    logic [7:0]        last_ctrl;
    logic [7:0]        sb [0:(1<<ADDR_W)-1];  // expected memory contents

    eeprom_ctrl_top #(.SCL_HALF(4)) i_dut (.*);
    eeprom_bus_model i_model (.*);

    always #50 CLK = ~CLK;

    task automatic check_value(input string name, input logic [31:0] got,
        input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("ERR %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
            $display("Test failures found");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // called on a falling edge
    task automatic wait_ack();
        int n;
        n = 0;
        while (ack !== 1'b1 && n < TIMEOUT)
        begin
            @(negedge CLK);
            n++;
        end
        if (ack !== 1'b1)
        begin
            $display("timeout, no ack within %0d cycles of the request", TIMEOUT);
            $display("Test failures found");
            $fatal(1, "ack timeout");
        end
    endtask

    task automatic issue_request(input logic is_write, input logic [ADDR_W-1:0] a,
        input logic [7:0] d);
        @(posedge CLK);
        wr    <= is_write;
        rd    <= !is_write;
        addr  <= a;
        wdata <= d;
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
        @(negedge CLK);
        check_value("busy", 32'(busy), 32'd1);  // one cycle after the strobe
    endtask

    task automatic end_request(output logic [7:0] data);
        wait_ack();
        data = rdata;
        @(negedge CLK);
        check_value("ack", 32'(ack), 32'd0);
        check_value("busy", 32'(busy), 32'd0);
    endtask

    task automatic write_byte(input logic [ADDR_W-1:0] a, input logic [7:0] d);
        logic [7:0] unused_rd;
        issue_request(1'b1, a, d);
        end_request(unused_rd);
        sb[a] = d;
    endtask

    task automatic read_byte(input logic [ADDR_W-1:0] a, output logic [7:0] d);
        issue_request(1'b0, a, 8'h00);
        end_request(d);
    endtask

    task automatic reset_outputs();
        check_value("ack", 32'(ack), 32'd0);
        check_value("busy", 32'(busy), 32'd0);
        check_value("sda_oe", 32'(sda_oe), 32'd0);
        check_value("scl", 32'(scl), 32'd1);
        check_value("sda_o", 32'(sda_o), 32'd1);
    endtask

    task automatic write_read_back();
        logic [ADDR_W-1:0] a;
        logic [7:0]        d;
        logic [7:0]        got;
        a = ADDR_W'($urandom());
        d = 8'($urandom());
        write_byte(a, d);
        read_byte(a, got);
        check_value("rdata", 32'(got), 32'(d));
    endtask

    // page bits travel in the control byte
    task automatic page_bits_in_ctrl();
        logic [ADDR_W-1:0] a;
        logic [7:0]        d;
        logic [7:0]        got;
        for (int p = 0; p < 8; p++)
        begin
            a = {3'(p), 8'($urandom())};
            d = 8'($urandom());
            write_byte(a, d);
            check_value("last_ctrl", 32'(last_ctrl), 32'({DEV_CODE, a[10:8], 1'b0}));
            check_value("model mem", 32'(i_model.mem[a]), 32'(d));
            read_byte(a, got);
            check_value("last_ctrl", 32'(last_ctrl), 32'({DEV_CODE, a[10:8], 1'b1}));
            check_value("rdata", 32'(got), 32'(d));
        end
    endtask

    task automatic busy_strobe_ignored();
        logic [ADDR_W-1:0] a1;
        logic [ADDR_W-1:0] a2;
        logic [7:0]        d1;
        logic [7:0]        keep;
        logic [7:0]        unused_rd;
        int                acks;
        a1   = ADDR_W'($urandom());
        a2   = a1 ^ 11'h2a5;
        d1   = 8'($urandom());
        keep = i_model.mem[a2];
        issue_request(1'b1, a1, d1);
        repeat (10) @(posedge CLK);
        wr    <= 1'b1;  // lands mid frame
        addr  <= a2;
        wdata <= ~keep;
        @(posedge CLK);
        wr <= 1'b0;
        @(negedge CLK);
        check_value("busy", 32'(busy), 32'd1);
        end_request(unused_rd);
        sb[a1] = d1;
        acks = 0;
        repeat (QUIET)
        begin
            @(negedge CLK);
            if (ack)
                acks++;
        end
        check_value("extra acks", 32'(acks), 32'd0);
        check_value("model mem", 32'(i_model.mem[a2]), 32'(keep));
        check_value("model mem", 32'(i_model.mem[a1]), 32'(d1));
    endtask

    task automatic bulk_random_loop();
        logic [ADDR_W-1:0] addrs [$];
        logic [ADDR_W-1:0] a;
        logic [7:0]        d;
        logic [7:0]        got;
        for (int i = 0; i < 20; i++)
        begin
            a = ADDR_W'($urandom());
            d = 8'($urandom());
            write_byte(a, d);
            addrs.push_back(a);
        end
        foreach (addrs[i])
        begin
            read_byte(addrs[i], got);
            check_value("rdata", 32'(got), 32'(sb[addrs[i]]));
        end
    endtask

    initial
    begin
        void'($urandom(32'h0ac8f741));
        CLK   = 1'b0;
        RESET = 1'b1;
        wr    = 1'b0;
        rd    = 1'b0;
        addr  = '0;
        wdata = '0;
        repeat (5) @(posedge CLK);
        RESET <= 1'b0;
        @(negedge CLK);
        reset_outputs();
        write_read_back();
        page_bits_in_ctrl();
        busy_strobe_ignored();
        bulk_random_loop();
        $display("All tests passed!");
        $finish;
    end

endmodule

/* filelist.f */
logic/eeprom_pkg.sv
logic/eeprom_req_capture.sv
logic/eeprom_frame_seq.sv
logic/eeprom_bit_engine.sv
logic/eeprom_ctrl_top.sv
bench/eeprom_bus_model.sv
bench/eeprom_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the EEPROM controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module eeprom_ctrl_tb -f filelist.f \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/Veeprom_ctrl_tb > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -q 'Test failures found' sim.log && exit 1
grep -q 'All tests passed!' sim.log || { echo "no pass line in sim.log"; exit 1; }
exit 0
